// ==== Bender.yml ====
package:
  name: bdCore

sources:
  - src/bdCorePkg.sv
  - src/bdRegFile.sv
  - src/hostWordDecoder.sv
  - src/downstreamEncoder.sv
  - src/upstreamPacker.sv
  - src/regReporter.sv
  - src/hostOutArbiter.sv
  - src/bdCoreTop.sv
  - target: test
    files:
      - tests/bdCoreTb.sv

// ==== filelist.f ====
src/bdCorePkg.sv
src/bdRegFile.sv
src/hostWordDecoder.sv
src/downstreamEncoder.sv
src/upstreamPacker.sv
src/regReporter.sv
src/hostOutArbiter.sv
src/bdCoreTop.sv
tests/bdCoreTb.sv

// ==== src/bdCorePkg.sv ====
package bdCorePkg;

  // ----------------------------------------------------------
  // Word widths
  // ----------------------------------------------------------
  localparam int HostWordW = 32;
  localparam int DownWordW = 21;   // Chip downstream word
  localparam int UpWordW   = 34;   // Chip upstream word
  localparam int RegIdW    = 5;
  localparam int RegDataW  = 16;
  localparam int LeafW     = 6;
  localparam int PayloadW  = 20;
  localparam int KindW     = 2;    // Top bits of every host word
  localparam int TagW      = 8;    // Top byte of every output host word

  typedef logic [HostWordW-1:0] hostWordT;
  typedef logic [DownWordW-1:0] bdDownWordT;  // Bit 20 set marks a leaf header
  typedef logic [UpWordW-1:0]   bdUpWordT;
  typedef logic [RegIdW-1:0]    regIdT;
  typedef logic [RegDataW-1:0]  regDataT;
  typedef logic [LeafW-1:0]     leafT;
  typedef logic [PayloadW-1:0]  payloadT;

  // ----------------------------------------------------------
  // Field positions and codes
  // ----------------------------------------------------------
  localparam int IdLsb   = 24;     // Channel or leaf number starts here
  localparam int UpSplit = 24;     // Upstream bits below this go out in the low word

  localparam logic [KindW-1:0] KindDown = 2'd0;
  localparam logic [KindW-1:0] KindReg  = 2'd2;
  localparam logic [KindW-1:0] KindChan = 2'd3;

  // Output tags, all of kind 1
  localparam logic [TagW-1:0] TagUpLow  = 8'h40;
  localparam logic [TagW-1:0] TagUpHigh = 8'h41;
  localparam logic [TagW-1:0] TagReport = 8'h42;

  localparam int    NumRegs       = 31;    // Registers 0 to 30
  localparam regIdT NopReg        = 5'd31; // Writes here vanish
  localparam regIdT RegDownEnable = 5'd0;  // Bit 0 opens the downstream path
  localparam regIdT RegUpEnable   = 5'd1;  // Bit 0 opens the upstream path
  localparam regIdT ChanReadback  = 5'd0;  // Data field names the register to report

  // Host output arbiter, A is the upstream packer and B the reporter
  typedef enum logic [1:0] {
    ArbIdle,
    ArbServeA,
    ArbServeB,
    ArbRelease
  } arbStateT;

endpackage

// ==== src/bdCoreTop.sv ====
module bdCoreTop (
  input  logic                  okClk,
  input  logic                  rst,
  // Host side
  input  bdCorePkg::hostWordT   hostInData,
  input  logic                  hostInValid,
  output logic                  hostInReady,
  output bdCorePkg::hostWordT   hostOutData,
  output logic                  hostOutValid,
  input  logic                  hostOutReady,
  // Chip side
  output bdCorePkg::bdDownWordT bdOutData,
  output logic                  bdOutValid,
  input  logic                  bdOutReady,
  input  bdCorePkg::bdUpWordT   bdInData,
  input  logic                  bdInValid,
  output logic                  bdInReady
);

  // Register file ports
  logic               regWe;
  bdCorePkg::regIdT   regWAddr;
  bdCorePkg::regDataT regWData;
  bdCorePkg::regIdT   regRAddr;
  bdCorePkg::regDataT regRData;
  logic               downEnable;
  logic               upEnable;

  // Decoder to encoder and reporter
  logic               downReq;
  logic               downAck;
  bdCorePkg::leafT    downLeaf;
  bdCorePkg::payloadT downPayload;
  logic               rbReq;
  logic               rbAck;
  bdCorePkg::regIdT   rbRegId;

  // Peers to arbiter
  logic                upReq;
  logic                upAck;
  bdCorePkg::hostWordT upWord;
  logic                repReq;
  logic                repAck;
  bdCorePkg::hostWordT repWord;

  bdRegFile regFile (
    .okClk, .rst, .regWe, .regWAddr, .regWData, .regRAddr, .regRData,
    .downEnable, .upEnable
  );

  hostWordDecoder decoder (
    .okClk, .rst, .hostInData, .hostInValid, .hostInReady,
    .regWe, .regWAddr, .regWData,
    .downReq, .downAck, .downLeaf, .downPayload,
    .rbReq, .rbAck, .rbRegId
  );

  downstreamEncoder encoder (
    .okClk, .rst, .downEnable, .downReq, .downAck, .downLeaf, .downPayload,
    .bdOutData, .bdOutValid, .bdOutReady
  );

  upstreamPacker packer (
    .okClk, .rst, .upEnable, .bdInData, .bdInValid, .bdInReady,
    .upReq, .upAck, .upWord
  );

  regReporter reporter (
    .okClk, .rst, .rbReq, .rbAck, .rbRegId, .regRAddr, .regRData,
    .repReq, .repAck, .repWord
  );

  // Packer is peer A, reporter is peer B
  hostOutArbiter arbiter (
    .okClk, .rst, .upReq, .upAck, .upWord, .repReq, .repAck, .repWord,
    .hostOutData, .hostOutValid, .hostOutReady
  );

endmodule

// ==== src/bdRegFile.sv ====
module bdRegFile (
  input  logic               okClk,
  input  logic               rst,
  input  logic               regWe,
  input  bdCorePkg::regIdT   regWAddr,
  input  bdCorePkg::regDataT regWData,
  input  bdCorePkg::regIdT   regRAddr,
  output bdCorePkg::regDataT regRData,
  output logic               downEnable,
  output logic               upEnable
);

  bdCorePkg::regDataT regs [bdCorePkg::NumRegs];  // No storage behind NopReg

  // Configuration is cleared on reset, so both paths start closed
  always_ff @(posedge okClk) begin
    if (rst) begin
      for (int i = 0; i < bdCorePkg::NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (regWe && (regWAddr != bdCorePkg::NopReg)) begin
      regs[regWAddr] <= regWData;
    end
  end

  // Reading the no-op register gives zero
  assign regRData = (regRAddr == bdCorePkg::NopReg) ? '0 : regs[regRAddr];

  assign downEnable = regs[bdCorePkg::RegDownEnable][0];
  assign upEnable   = regs[bdCorePkg::RegUpEnable][0];

endmodule

// ==== src/downstreamEncoder.sv ====
module downstreamEncoder (
  input  logic                  okClk,
  input  logic                  rst,
  input  logic                  downEnable,
  input  logic                  downReq,
  output logic                  downAck,
  input  bdCorePkg::leafT       downLeaf,
  input  bdCorePkg::payloadT    downPayload,
  output bdCorePkg::bdDownWordT bdOutData,
  output logic                  bdOutValid,
  input  logic                  bdOutReady
);

  typedef enum logic [1:0] {
    EncIdle,   // Empty, may latch a request
    EncHold,   // Word latched, waiting for downEnable
    EncHead,   // Leaf header on the chip bus
    EncPay     // Payload word on the chip bus
  } encStateT;

  encStateT           state;
  bdCorePkg::leafT    wordLeaf;   // Latched request
  bdCorePkg::payloadT wordPay;
  bdCorePkg::leafT    lastLeaf;   // Leaf of the last header sent
  logic               leafValid;  // Low until the first header goes out
  logic               take;
  logic               newLeaf;

  assign take    = (state == EncIdle) && downReq && !downAck;
  assign newLeaf = !leafValid || (lastLeaf != wordLeaf);

  // Output word comes straight from the state, so it is stable while valid
  assign bdOutValid = (state == EncHead) || (state == EncPay);
  assign bdOutData  = (state == EncHead)
                    ? {1'b1, {(bdCorePkg::DownWordW-1-bdCorePkg::LeafW){1'b0}}, wordLeaf}
                    : {1'b0, wordPay};

  always_ff @(posedge okClk) begin
    if (rst) begin
      state     <= EncIdle;
      downAck   <= 1'b0;
      leafValid <= 1'b0;
    end else begin
      if (downAck && !downReq) downAck <= 1'b0;  // Return to zero
      case (state)
        EncIdle: begin
          if (take) begin
            downAck <= 1'b1;
            state   <= EncHold;
          end
        end
        // Header only when the leaf changes
        EncHold: if (downEnable) state <= newLeaf ? EncHead : EncPay;
        EncHead: begin
          if (bdOutReady) begin
            leafValid <= 1'b1;
            state     <= EncHold;  // Payload goes out on the next pass
          end
        end
        EncPay:  if (bdOutReady) state <= EncIdle;
        default: state <= EncIdle;
      endcase
    end
  end

  always_ff @(posedge okClk) begin
    if (take) begin
      wordLeaf <= downLeaf;
      wordPay  <= downPayload;
    end
    if ((state == EncHead) && bdOutReady) lastLeaf <= wordLeaf;
  end

endmodule

// ==== src/hostOutArbiter.sv ====
module hostOutArbiter (
  input  logic                okClk,
  input  logic                rst,
  input  logic                upReq,
  output logic                upAck,
  input  bdCorePkg::hostWordT upWord,
  input  logic                repReq,
  output logic                repAck,
  input  bdCorePkg::hostWordT repWord,
  output bdCorePkg::hostWordT hostOutData,
  output logic                hostOutValid,
  input  logic                hostOutReady
);

  bdCorePkg::arbStateT state;
  logic                lastB;  // Reporter got the last grant

  // Peers hold their words stable while req is up
  assign hostOutValid = (state == bdCorePkg::ArbServeA) || (state == bdCorePkg::ArbServeB);
  assign hostOutData  = (state == bdCorePkg::ArbServeB) ? repWord : upWord;

  // ----------------------------------------------------------
  // Round robin grant and four-phase completion
  // ----------------------------------------------------------
  always_ff @(posedge okClk) begin
    if (rst) begin
      state  <= bdCorePkg::ArbIdle;
      lastB  <= 1'b0;
      upAck  <= 1'b0;
      repAck <= 1'b0;
    end else begin
      case (state)
        bdCorePkg::ArbIdle: begin
          if (upReq && (!repReq || lastB)) begin
            state <= bdCorePkg::ArbServeA;
          end else if (repReq) begin
            state <= bdCorePkg::ArbServeB;
          end
        end
        bdCorePkg::ArbServeA: begin
          if (hostOutReady) begin  // Host took the word
            upAck <= 1'b1;
            lastB <= 1'b0;
            state <= bdCorePkg::ArbRelease;
          end
        end
        bdCorePkg::ArbServeB: begin
          if (hostOutReady) begin
            repAck <= 1'b1;
            lastB  <= 1'b1;
            state  <= bdCorePkg::ArbRelease;
          end
        end
        bdCorePkg::ArbRelease: begin
          // Drop ack once the served peer has let go of req
          if (!(upAck && upReq) && !(repAck && repReq)) begin
            upAck  <= 1'b0;
            repAck <= 1'b0;
            state  <= bdCorePkg::ArbIdle;
          end
        end
        default: state <= bdCorePkg::ArbIdle;
      endcase
    end
  end

endmodule

// ==== src/hostWordDecoder.sv ====
module hostWordDecoder (
  input  logic               okClk,
  input  logic               rst,
  input  bdCorePkg::hostWordT hostInData,
  input  logic               hostInValid,
  output logic               hostInReady,
  output logic               regWe,
  output bdCorePkg::regIdT   regWAddr,
  output bdCorePkg::regDataT regWData,
  output logic               downReq,
  input  logic               downAck,
  output bdCorePkg::leafT    downLeaf,
  output bdCorePkg::payloadT downPayload,
  output logic               rbReq,
  input  logic               rbAck,
  output bdCorePkg::regIdT   rbRegId
);

  typedef enum logic [2:0] {
    DecStart,     // First cycle out of reset, input held off
    DecIdle,      // Ready for a host word
    DecDown,      // downReq up until the encoder latches
    DecDownRel,   // Waiting for downAck to fall
    DecRb,        // rbReq up until the report is done
    DecRbRel
  } decStateT;

  decStateT                    state;
  logic [bdCorePkg::KindW-1:0] kind;
  bdCorePkg::regIdT            idField;  // Channel number
  logic                        accept;

  assign kind    = hostInData[bdCorePkg::HostWordW-1 -: bdCorePkg::KindW];
  assign idField = hostInData[bdCorePkg::IdLsb +: bdCorePkg::RegIdW];
  assign accept  = hostInValid && hostInReady;

  assign hostInReady = (state == DecIdle);
  assign downReq     = (state == DecDown);
  assign rbReq       = (state == DecRb);

  // Register writes land in the accept cycle itself
  assign regWe    = accept && (kind == bdCorePkg::KindReg);
  assign regWAddr = hostInData[bdCorePkg::RegDataW +: bdCorePkg::RegIdW];  // Same spot as in a report
  assign regWData = hostInData[bdCorePkg::RegDataW-1:0];

  // ----------------------------------------------------------
  // Sequencing of the two four-phase exchanges
  // ----------------------------------------------------------
  always_ff @(posedge okClk) begin
    if (rst) begin
      state <= DecStart;
    end else begin
      case (state)
        DecStart: state <= DecIdle;
        DecIdle: begin
          if (accept && (kind == bdCorePkg::KindDown)) begin
            state <= DecDown;
          end else if (accept && (kind == bdCorePkg::KindChan)
                       && (idField == bdCorePkg::ChanReadback)) begin
            state <= DecRb;
          end  // Other channels and kind 1 are dropped
        end
        DecDown:    if (downAck)  state <= DecDownRel;
        DecDownRel: if (!downAck) state <= DecIdle;
        DecRb:      if (rbAck)    state <= DecRbRel;
        DecRbRel:   if (!rbAck)   state <= DecIdle;
        default:    state <= DecIdle;
      endcase
    end
  end

  // Fields stay put for the whole exchange since no word is taken meanwhile
  always_ff @(posedge okClk) begin
    if (accept) begin
      downLeaf    <= hostInData[bdCorePkg::IdLsb +: bdCorePkg::LeafW];
      downPayload <= hostInData[bdCorePkg::PayloadW-1:0];
      rbRegId     <= hostInData[bdCorePkg::RegIdW-1:0];  // Register to report
    end
  end

endmodule

// ==== src/regReporter.sv ====
module regReporter (
  input  logic                okClk,
  input  logic                rst,
  input  logic                rbReq,
  output logic                rbAck,
  input  bdCorePkg::regIdT    rbRegId,
  output bdCorePkg::regIdT    regRAddr,
  input  bdCorePkg::regDataT  regRData,
  output logic                repReq,
  input  logic                repAck,
  output bdCorePkg::hostWordT repWord
);

  typedef enum logic [1:0] {
    RpIdle,
    RpReq,    // Report offered to the arbiter
    RpRel,    // Waiting for the arbiter to drop repAck
    RpAck     // Report done, now ack the decoder
  } rpStateT;

  rpStateT state;

  assign regRAddr = rbRegId;  // Decoder holds it for the whole exchange
  assign repReq   = (state == RpReq);
  assign rbAck    = (state == RpAck);

  always_ff @(posedge okClk) begin
    if (rst) begin
      state <= RpIdle;
    end else begin
      case (state)
        RpIdle:  if (rbReq)   state <= RpReq;
        RpReq:   if (repAck)  state <= RpRel;
        RpRel:   if (!repAck) state <= RpAck;
        RpAck:   if (!rbReq)  state <= RpIdle;
        default: state <= RpIdle;
      endcase
    end
  end

  // Value is sampled once, when the command is taken
  always_ff @(posedge okClk) begin
    if ((state == RpIdle) && rbReq) begin
      repWord <= {bdCorePkg::TagReport,
                  {(bdCorePkg::HostWordW-bdCorePkg::TagW-bdCorePkg::RegIdW
                    -bdCorePkg::RegDataW){1'b0}},
                  rbRegId, regRData};
    end
  end

endmodule

// ==== src/upstreamPacker.sv ====
module upstreamPacker (
  input  logic                okClk,
  input  logic                rst,
  input  logic                upEnable,
  input  bdCorePkg::bdUpWordT bdInData,
  input  logic                bdInValid,
  output logic                bdInReady,
  output logic                upReq,
  input  logic                upAck,
  output bdCorePkg::hostWordT upWord
);

  typedef enum logic [2:0] {
    PkIdle,
    PkLowReq,    // Low word offered to the arbiter
    PkLowRel,
    PkHighReq,   // High word offered
    PkHighRel
  } pkStateT;

  pkStateT             state;
  bdCorePkg::bdUpWordT chipWord;  // Held across both host words
  logic                highSel;

  // Enable is cleared by reset, so ready is low right after it
  assign bdInReady = (state == PkIdle) && upEnable;
  assign upReq     = (state == PkLowReq) || (state == PkHighReq);
  assign highSel   = (state == PkHighReq) || (state == PkHighRel);

  // Low word carries bits 23..0, high word bits 33..24 right aligned
  assign upWord = highSel
    ? {bdCorePkg::TagUpHigh,
       {(bdCorePkg::HostWordW-bdCorePkg::TagW-bdCorePkg::UpWordW+bdCorePkg::UpSplit){1'b0}},
       chipWord[bdCorePkg::UpWordW-1:bdCorePkg::UpSplit]}
    : {bdCorePkg::TagUpLow, chipWord[bdCorePkg::UpSplit-1:0]};

  always_ff @(posedge okClk) begin
    if (rst) begin
      state <= PkIdle;
    end else begin
      case (state)
        PkIdle:    if (bdInValid && bdInReady) state <= PkLowReq;
        PkLowReq:  if (upAck)  state <= PkLowRel;
        PkLowRel:  if (!upAck) state <= PkHighReq;
        PkHighReq: if (upAck)  state <= PkHighRel;
        PkHighRel: if (!upAck) state <= PkIdle;
        default:   state <= PkIdle;
      endcase
    end
  end

  always_ff @(posedge okClk) begin
    if (bdInValid && bdInReady) chipWord <= bdInData;
  end

endmodule

// ==== tests/bdCoreTb.sv ====
module bdCoreTb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                  okClk;
  logic                  rst;
  bdCorePkg::hostWordT   hostInData;
  logic                  hostInValid;
  logic                  hostInReady;
  bdCorePkg::hostWordT   hostOutData;
  logic                  hostOutValid;
  logic                  hostOutReady;
  bdCorePkg::bdDownWordT bdOutData;
  logic                  bdOutValid;
  logic                  bdOutReady;
  bdCorePkg::bdUpWordT   bdInData;
  logic                  bdInValid;
  logic                  bdInReady;

  // Records from the stimulus file
  int          recTest [$];
  string       recType [$];
  logic [63:0] recVal  [$];
  logic        loaded;

  bdCorePkg::bdUpWordT   chipInQ [$];  // Chip words waiting for the chip driver
  bdCorePkg::bdDownWordT chipExp [$];
  bdCorePkg::hostWordT   hostExp [$];  // Matched per tag, not by interleaving
  logic                  pairOpen;     // Upstream low word seen, high word due

  int errors;
  int checks;
  int testsRun;
  int errorsMark;
  int checksMark;

  bdCoreTop DUT (
    .okClk, .rst, .hostInData, .hostInValid, .hostInReady,
    .hostOutData, .hostOutValid, .hostOutReady,
    .bdOutData, .bdOutValid, .bdOutReady, .bdInData, .bdInValid, .bdInReady
  );

  initial okClk = 1'b0;
  always #10 okClk = ~okClk;  // 20 ns period

  // Back-pressure from the chip and the host
  always @(posedge okClk) begin
    #2;
    bdOutReady   = ($urandom % 4) != 0;  // About one stall in four
    hostOutReady = ($urandom % 3) != 0;
  end

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------
  task automatic nextCycle();
    @(posedge okClk);
    #2;  // Inputs change just after the edge
  endtask

  task automatic sendHost(input bdCorePkg::hostWordT word);
    int gap;
    gap = $urandom % 3;
    repeat (gap) nextCycle();
    hostInData  = word;
    hostInValid = 1'b1;
    do begin
      @(negedge okClk);
    end while (!hostInReady);
    nextCycle();  // Word taken on this edge
    hostInValid = 1'b0;
  endtask

  task automatic sendChip(input bdCorePkg::bdUpWordT word);
    int gap;
    gap = $urandom % 3;
    repeat (gap) nextCycle();
    bdInData  = word;
    bdInValid = 1'b1;
    do begin
      @(negedge okClk);
    end while (!bdInReady);
    nextCycle();
    bdInValid = 1'b0;
  endtask

  // Chip side runs beside the host side so both streams overlap
  initial begin
    bdCorePkg::bdUpWordT word;
    forever begin
      nextCycle();
      if (chipInQ.size() != 0) begin
        word = chipInQ[0];
        sendChip(word);
        void'(chipInQ.pop_front());  // Popped once accepted, so drain waits for it
      end
    end
  end

  // ------------------------------------------------------------
  // Output checks, sampled mid cycle where everything is stable
  // ------------------------------------------------------------
  function automatic int firstWithTag(input logic [bdCorePkg::TagW-1:0] tag);
    foreach (hostExp[i]) begin
      if (hostExp[i][bdCorePkg::HostWordW-1 -: bdCorePkg::TagW] == tag) return i;
    end
    return -1;
  endfunction

  task automatic checkChipWord(input bdCorePkg::bdDownWordT got);
    bdCorePkg::bdDownWordT exp;
    assert (chipExp.size() != 0) else begin
      $display("Chip word %h appeared at %0t ns while none was expected", got, $time);
      errors++;
    end
    if (chipExp.size() != 0) begin
      exp = chipExp.pop_front();
      checks++;
      assert (got == exp) else begin
        $display("ERROR at %0t ns: bdOutData expected %h, got %h", $time, exp, got);
        errors++;
      end
    end
  endtask

  task automatic checkHostWord(input bdCorePkg::hostWordT got);
    logic [bdCorePkg::TagW-1:0] tag;
    bdCorePkg::hostWordT        exp;
    int                         idx;
    tag = got[bdCorePkg::HostWordW-1 -: bdCorePkg::TagW];
    idx = firstWithTag(tag);
    assert (idx >= 0) else begin
      $display("Host word %h with tag %h arrived at %0t ns but none was expected",
               got, tag, $time);
      errors++;
    end
    if (idx >= 0) begin
      exp = hostExp[idx];
      hostExp.delete(idx);
      checks++;
      assert (got == exp) else begin
        $display("ERROR at %0t ns: hostOutData expected %h, got %h", $time, exp, got);
        errors++;
      end
    end
    // Low half of a chip word always goes first
    if (tag == bdCorePkg::TagUpLow) begin
      assert (!pairOpen) else begin
        $display("Two upstream low words in a row at %0t ns", $time);
        errors++;
      end
      pairOpen = 1'b1;
    end else if (tag == bdCorePkg::TagUpHigh) begin
      assert (pairOpen) else begin
        $display("Upstream high word at %0t ns came before its low word", $time);
        errors++;
      end
      pairOpen = 1'b0;
    end
  endtask

  always @(negedge okClk) begin
    if (!rst && bdOutValid && bdOutReady) checkChipWord(bdOutData);
    if (!rst && hostOutValid && hostOutReady) checkHostWord(hostOutData);
  end

  // ------------------------------------------------------------
  // Test sequencing
  // ------------------------------------------------------------
  task automatic loadRecords();
    int          fd;
    string       line;
    int          tn;
    string       typ;
    logic [63:0] val;
    fd = $fopen("tests/bdCore_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tests/bdCore_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0 && line[0] != "#") begin
          if ($sscanf(line, "%d %s %h", tn, typ, val) == 3) begin
            recTest.push_back(tn);
            recType.push_back(typ);
            recVal.push_back(val);
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic drain();
    while (chipInQ.size() != 0 || chipExp.size() != 0 || hostExp.size() != 0) begin
      nextCycle();
    end
    repeat (20) nextCycle();  // Quiet window, any stray word shows up here
  endtask

  task automatic checkResetState();
    @(negedge okClk);  // First cycle out of reset
    checks++;
    assert (!hostInReady && !bdInReady && !hostOutValid && !bdOutValid) else begin
      $display("Handshake outputs were not idle in the first cycle after reset at %0t ns",
               $time);
      errors++;
    end
    nextCycle();
  endtask

  task automatic pulseReset();
    drain();
    rst = 1'b1;
    repeat (4) nextCycle();
    rst      = 1'b0;
    pairOpen = 1'b0;
    checkResetState();
  endtask

  task automatic runRecord(input string typ, input logic [63:0] val);
    case (typ)
      "HI": sendHost(val[bdCorePkg::HostWordW-1:0]);
      "CI": chipInQ.push_back(val[bdCorePkg::UpWordW-1:0]);
      "CO": chipExp.push_back(val[bdCorePkg::DownWordW-1:0]);
      "HO": hostExp.push_back(val[bdCorePkg::HostWordW-1:0]);
      "WT": repeat (int'(val)) nextCycle();
      "RS": pulseReset();
      default: begin
        $display("Unknown record type %s in the stimulus file", typ);
        errors++;
      end
    endcase
  endtask

  task automatic finishTest(input int tn);
    drain();
    testsRun++;
    $display("Test %0d finished: %0d checks, %0d errors", tn,
             checks - checksMark, errors - errorsMark);
    checksMark = checks;
    errorsMark = errors;
  endtask

  // Watchdog sized from the record count
  initial begin
    wait (loaded === 1'b1);
    #((recTest.size() * 200 + 1000) * 20);
    $display("Timeout: the tests did not finish within %0d clock cycles",
             recTest.size() * 200 + 1000);
    $display("Errors found");
    $finish;
  end

  initial begin
    int curTest;
    int i;
    void'($urandom(68765));
    loaded       = 1'b0;
    errors       = 0;
    checks       = 0;
    testsRun     = 0;
    errorsMark   = 0;
    checksMark   = 0;
    pairOpen     = 1'b0;
    rst          = 1'b1;
    hostInData   = '0;
    hostInValid  = 1'b0;
    hostOutReady = 1'b0;
    bdOutReady   = 1'b0;
    bdInData     = '0;
    bdInValid    = 1'b0;
    loadRecords();
    repeat (16) @(posedge okClk);
    #2;
    rst = 1'b0;
    checkResetState();
    curTest = (recTest.size() != 0) ? recTest[0] : 0;
    for (i = 0; i < recTest.size(); i++) begin
      if (recTest[i] != curTest) begin
        finishTest(curTest);
        curTest = recTest[i];
      end
      runRecord(recType[i], recVal[i]);
    end
    if (recTest.size() != 0) finishTest(curTest);
    $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tests/bdCore_stim.txt ====
# test  type  hex value
# HI host word in, CI chip word in, CO expected chip word, HO expected host word, WT wait, RS reset
1 HI 80051234
1 HI 9F00FFFF
1 HI 45000001
1 HI C0000005
1 HO 42051234
1 HI C000001F
1 HO 421F0000
2 HI 80000001
2 HI 05012345
2 CO 100005
2 CO 012345
2 HI 050ABCDE
2 CO 0ABCDE
2 HI 07000001
2 CO 100007
2 CO 000001
3 HI 80000000
3 HI 03055555
3 WT 20
3 HI 80000001
3 CO 100003
3 CO 055555
4 CI 3ABCDEF12
4 WT 10
4 HI 80010001
4 HO 40CDEF12
4 HO 410003AB
5 CI 2FEDCBA98
5 HO 40DCBA98
5 HO 410002FE
5 CI 100000001
5 HO 40000001
5 HO 41000100
5 HI C0000000
5 HO 42000001
5 HI C0000001
5 HO 42010001
6 HI 03000111
6 CO 000111
6 RS 0
6 HI C0000000
6 HO 42000000
6 HI 80000001
6 HI 03000222
6 CO 100003
6 CO 000222
